// ==== sources.f ====
verilog/soc_pkg.sv
verilog/soc_reset.sv
verilog/pi1_router.sv
verilog/dev_table.sv
verilog/gpio_ctrl.sv
verilog/int_ctrl.sv
verilog/soc_top.sv
verif/tb_clock.sv
verif/tb_soc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_soc.sv ====
`timescale 1ns/1ps

module tb_soc import soc_pkg::*;;
	localparam int rst_bits = 4;

	logic                  clk100mhz;
	logic                  rst_p;
	logic                  rst_req;
	pi1_op_t               pi1_op_i;
	logic [addr_bitsz-1:0] pi1_addr_i;
	logic [arch_bitsz-1:0] pi1_data_i;
	logic [sel_bitsz-1:0]  pi1_sel_i;
	logic [arch_bitsz-1:0] pi1_data_o;
	logic                  pi1_rdy_o;
	logic [gpio_count-1:0] gp_i;
	logic [gpio_count-1:0] gp_o;
	logic                  ext_irq_i;
	logic                  ext_irq_ack_o;
	logic                  intrqst_o;
	logic                  intrdy_i;
	logic                  sys_rst_o;

	int checks = 0;
	int errors = 0;

	tb_clock #(.rst_cycles(8)) u_clock (
		.rst_req_i (rst_req),
		.clk_o     (clk100mhz),
		.rst_o     (rst_p)
	);

	soc_top #(
		.rst_cntr_bitsz (rst_bits)
	) dut (
		.clk100mhz     (clk100mhz),
		.rst_p         (rst_p),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.pi1_data_i    (pi1_data_i),
		.pi1_sel_i     (pi1_sel_i),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o),
		.gp_i          (gp_i),
		.gp_o          (gp_o),
		.ext_irq_i     (ext_irq_i),
		.ext_irq_ack_o (ext_irq_ack_o),
		.intrqst_o     (intrqst_o),
		.intrdy_i      (intrdy_i),
		.sys_rst_o     (sys_rst_o)
	);

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	// slave windows sit back to back from word 0
	function automatic logic [addr_bitsz-1:0] slave_addr(input logic [1:0] slave,
			input int offset);
		return addr_bitsz'(slave) * addr_bitsz'(map_sz_words) + addr_bitsz'(offset);
	endfunction

	function automatic logic [arch_bitsz-1:0] expected_entry(input int k);
		logic [15:0] id;
		logic        use_int;
		id      = dev_id_invalid;
		use_int = (k == int'(s_gpio));
		if (k == int'(s_devtbl)) begin
			id = dev_id_devtbl;
		end else if (k == int'(s_gpio)) begin
			id = dev_id_gpio;
		end else if (k == int'(s_intctrl)) begin
			id = dev_id_intctrl;
		end
		return {15'd0, use_int, id};
	endfunction

	// ready is due two rising edges after the request goes out
	task automatic bus_xfer(input pi1_op_t op, input logic [addr_bitsz-1:0] addr,
			input logic [arch_bitsz-1:0] wdata, input logic [sel_bitsz-1:0] sel,
			output logic [arch_bitsz-1:0] rdata);
		int cycles;
		cycles = 0;
		@(negedge clk100mhz);
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = wdata;
		pi1_sel_i  = sel;
		do begin
			@(negedge clk100mhz);
			cycles++;
		end while (!pi1_rdy_o && cycles < 16);
		rdata = pi1_data_o;
		if (!pi1_rdy_o) begin
			report_problem($sformatf("no pi1_rdy_o for the request at address %h", addr));
		end else begin
			check_value("pi1_rdy_o latency", 32'(cycles), 32'd2);
		end
		pi1_op_i = op_nop;
	endtask

	task automatic bus_write(input logic [addr_bitsz-1:0] addr,
			input logic [arch_bitsz-1:0] data, input logic [sel_bitsz-1:0] sel);
		logic [arch_bitsz-1:0] unused;
		bus_xfer(op_wr, addr, data, sel, unused);
	endtask

	task automatic bus_read(input logic [addr_bitsz-1:0] addr,
			output logic [arch_bitsz-1:0] data);
		bus_xfer(op_rd, addr, '0, '0, data);
	endtask

	task automatic bus_rdwr(input logic [addr_bitsz-1:0] addr, input logic [arch_bitsz-1:0] data,
			output logic [arch_bitsz-1:0] old);
		bus_xfer(op_rdwr, addr, data, 4'h1, old);
	endtask

	task automatic wait_intrqst(input int max_cycles);
		int n;
		n = 0;
		while (!intrqst_o && n < max_cycles) begin
			@(negedge clk100mhz);
			n++;
		end
		if (!intrqst_o) begin
			report_problem("timeout waiting for intrqst_o to rise");
		end
	endtask

	task automatic wait_reset_release(input int max_cycles, output int cycles);
		cycles = 0;
		while (sys_rst_o && cycles < max_cycles) begin
			@(negedge clk100mhz);
			cycles++;
		end
		if (sys_rst_o) begin
			report_problem("timeout waiting for sys_rst_o to fall");
		end
	endtask

	// pulses intrdy_i for one cycle and returns the external ack seen right after it
	task automatic ack_interrupt(output logic ack_seen);
		@(negedge clk100mhz);
		intrdy_i = 1'b1;
		@(negedge clk100mhz);
		intrdy_i = 1'b0;
		ack_seen = ext_irq_ack_o;
		if (intrqst_o) begin
			report_problem("intrqst_o did not drop after the intrdy_i pulse");
		end
	endtask

	task automatic test_reset();
		int waited;
		int cycles;
		waited = 0;
		@(negedge clk100mhz);
		while (rst_p && waited < 50) begin
			@(negedge clk100mhz);
			waited++;
		end
		if (rst_p) begin
			report_problem("rst_p was never released");
		end
		// one counter step has already passed when rst_p is first seen low
		wait_reset_release(40, cycles);
		check_value("sys_rst_o release cycles", 32'(cycles + 1), 32'((1 << rst_bits) - 1));
		check_value("gp_o", 32'(gp_o), 32'd0);
		check_value("intrqst_o", 32'(intrqst_o), 32'd0);
		check_value("ext_irq_ack_o", 32'(ext_irq_ack_o), 32'd0);
		check_value("pi1_rdy_o", 32'(pi1_rdy_o), 32'd0);
	endtask

	task automatic test_dev_table();
		logic [arch_bitsz-1:0] rd;
		for (int k = 0; k < slave_count; k++) begin
			bus_read(slave_addr(s_devtbl, 2 * k), rd);
			check_value($sformatf("pi1_data_o (devtbl word %0d)", 2 * k), rd, expected_entry(k));
			bus_read(slave_addr(s_devtbl, 2 * k + 1), rd);
			check_value($sformatf("pi1_data_o (devtbl word %0d)", 2 * k + 1), rd,
				32'(map_sz_words));
		end
		bus_read(slave_addr(s_devtbl, 256), rd);
		check_value("pi1_data_o (soc_id)", rd, 32'(soc_id));
	endtask

	task automatic test_gpio();
		logic [arch_bitsz-1:0] rd;
		bus_write(slave_addr(s_gpio, 0), 32'h5A, 4'h1);
		check_value("gp_o", 32'(gp_o), 32'h5A);
		bus_read(slave_addr(s_gpio, 0), rd);
		check_value("pi1_data_o (gpio out)", rd, 32'h5A);
		bus_rdwr(slave_addr(s_gpio, 0), 32'hC3, rd);
		check_value("pi1_data_o (gpio rdwr old)", rd, 32'h5A);
		check_value("gp_o", 32'(gp_o), 32'hC3);
		// byte lane 0 off
		bus_write(slave_addr(s_gpio, 0), 32'hFF, 4'hE);
		check_value("gp_o", 32'(gp_o), 32'hC3);
		@(negedge clk100mhz);
		gp_i = 8'h96;
		repeat (4) @(negedge clk100mhz);
		bus_read(slave_addr(s_gpio, 1), rd);
		check_value("pi1_data_o (gpio in)", rd, 32'h96);
	endtask

	task automatic test_interrupts();
		logic [arch_bitsz-1:0] rd;
		logic                  ack_seen;
		logic                  leaked;
		bus_write(slave_addr(s_intctrl, 1), 32'h3, 4'h1);
		bus_write(slave_addr(s_gpio, 2), 32'hFF, 4'h1);
		@(negedge clk100mhz);
		gp_i = ~gp_i;
		wait_intrqst(20);
		// external line joins while the gpio request is pending
		ext_irq_i = 1'b1;
		ack_interrupt(ack_seen);
		check_value("ext_irq_ack_o", 32'(ack_seen), 32'd0);
		bus_read(slave_addr(s_intctrl, 0), rd);
		check_value("pi1_data_o (int source)", rd, 32'(int_src_gpio));
		wait_intrqst(20);
		ack_interrupt(ack_seen);
		check_value("ext_irq_ack_o", 32'(ack_seen), 32'd1);
		ext_irq_i = 1'b0;
		// the ack lasts a single cycle
		@(negedge clk100mhz);
		check_value("ext_irq_ack_o", 32'(ext_irq_ack_o), 32'd0);
		bus_read(slave_addr(s_intctrl, 0), rd);
		check_value("pi1_data_o (int source)", rd, 32'(int_src_ext));
		// both sources disabled
		leaked = 1'b0;
		bus_write(slave_addr(s_intctrl, 1), 32'h0, 4'h1);
		@(negedge clk100mhz);
		gp_i      = ~gp_i;
		ext_irq_i = 1'b1;
		for (int n = 0; n < 12; n++) begin
			@(negedge clk100mhz);
			leaked = leaked | intrqst_o;
		end
		if (leaked) begin
			report_problem("intrqst_o rose with all sources disabled");
		end
		ext_irq_i = 1'b0;
	endtask

	task automatic test_invalid_space();
		logic [arch_bitsz-1:0] rd;
		logic [gpio_count-1:0] gp_before;
		bus_read(slave_addr(s_invalid, 5), rd);
		check_value("pi1_data_o (unmapped)", rd, 32'd0);
		bus_read(30'h3FFF_FFF0, rd);
		check_value("pi1_data_o (unmapped top)", rd, 32'd0);
		gp_before = gp_o;
		// same offsets as the gpio output, int enable, gpio mask and reset words
		bus_write(slave_addr(s_invalid, 0), 32'hFF, 4'hF);
		bus_write(slave_addr(s_invalid, 1), 32'h3, 4'hF);
		bus_write(slave_addr(s_invalid, 2), 32'h0, 4'hF);
		bus_write(slave_addr(s_invalid, 256), 32'h3, 4'hF);
		@(negedge clk100mhz);
		check_value("sys_rst_o", 32'(sys_rst_o), 32'd0);
		check_value("gp_o", 32'(gp_o), 32'(gp_before));
		bus_read(slave_addr(s_gpio, 2), rd);
		check_value("pi1_data_o (gpio mask)", rd, 32'hFF);
		bus_read(slave_addr(s_intctrl, 1), rd);
		check_value("pi1_data_o (int enable)", rd, 32'h0);
	endtask

	task automatic test_soft_reset();
		logic [arch_bitsz-1:0] rd;
		logic                  dropped;
		int                    cycles;
		bus_write(slave_addr(s_devtbl, 256), 32'h2, 4'h1);
		@(negedge clk100mhz);
		check_value("sys_rst_o", 32'(sys_rst_o), 32'd1);
		wait_reset_release(40, cycles);
		check_value("sys_rst_o warm cycles", 32'(cycles), 32'((1 << rst_bits) - 1));
		check_value("gp_o", 32'(gp_o), 32'd0);
		// power-off holds until the board reset
		dropped = 1'b0;
		bus_write(slave_addr(s_devtbl, 256), 32'h1, 4'h1);
		for (int n = 0; n < 40; n++) begin
			@(negedge clk100mhz);
			dropped = dropped | !sys_rst_o;
		end
		if (dropped) begin
			report_problem("sys_rst_o fell during power-off");
		end
		@(negedge clk100mhz);
		rst_req = 1'b1;
		@(negedge clk100mhz);
		rst_req = 1'b0;
		wait_reset_release(60, cycles);
		bus_read(slave_addr(s_devtbl, 256), rd);
		check_value("pi1_data_o (soc_id)", rd, 32'(soc_id));
	endtask

	initial begin
		rst_req    = 1'b0;
		pi1_op_i   = op_nop;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		gp_i       = '0;
		ext_irq_i  = 1'b0;
		intrdy_i   = 1'b0;
		test_reset();
		test_dev_table();
		test_gpio();
		test_interrupts();
		test_invalid_space();
		test_soft_reset();
		$display("tb_soc: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int rst_cycles = 8
) (
	input  logic rst_req_i,
	output logic clk_o,
	output logic rst_o
);
	int   rst_cnt = rst_cycles;
	logic req_q   = 1'b0;

	// 100 MHz
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// request is taken mid-cycle, reset itself moves on falling edges
	always @(posedge clk_o) begin
		req_q <= rst_req_i;
	end

	always @(negedge clk_o) begin
		if (req_q) begin
			rst_cnt <= rst_cycles;
		end else if (rst_cnt != 0) begin
			rst_cnt <= rst_cnt - 1;
		end
	end

	assign rst_o = (rst_cnt != 0);

endmodule

// ==== verilog/soc_top.sv ====
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
	parameter int rst_cntr_bitsz = 16
) (
	input  logic                  clk100mhz,
	input  logic                  rst_p,
	input  pi1_op_t               pi1_op_i,
	input  logic [addr_bitsz-1:0] pi1_addr_i,
	input  logic [arch_bitsz-1:0] pi1_data_i,
	input  logic [sel_bitsz-1:0]  pi1_sel_i,
	output logic [arch_bitsz-1:0] pi1_data_o,
	output logic                  pi1_rdy_o,
	input  logic [gpio_count-1:0] gp_i,
	output logic [gpio_count-1:0] gp_o,
	input  logic                  ext_irq_i,
	output logic                  ext_irq_ack_o,
	output logic                  intrqst_o,
	input  logic                  intrdy_i,
	output logic                  sys_rst_o
);
	// router to slave side, one entry per mapped slave
	pi1_op_t                  s_op   [slave_count-1];
	logic [map_off_bitsz-1:0] s_addr [slave_count-1];
	logic [arch_bitsz-1:0]    s_wdat [slave_count-1];
	logic [sel_bitsz-1:0]     s_sel  [slave_count-1];
	logic [arch_bitsz-1:0]    s_rdat [slave_count-1];
	logic                     s_rdy  [slave_count-1];

	logic                     sw_rst0;
	logic                     sw_rst1;
	logic [int_src_count-1:0] irq_rqst;
	logic [int_src_count-1:0] irq_rdy;

	// the external line goes straight to its arbiter slot
	assign irq_rqst[int_src_ext] = ext_irq_i;
	assign ext_irq_ack_o         = irq_rdy[int_src_ext];

	soc_reset #(
		.rst_cntr_bitsz (rst_cntr_bitsz)
	) u_reset (
		.clk100mhz (clk100mhz),
		.rst_p     (rst_p),
		.rst0_i    (sw_rst0),
		.rst1_i    (sw_rst1),
		.sys_rst_o (sys_rst_o)
	);

	pi1_router u_router (
		.clk100mhz  (clk100mhz),
		.rst_i      (sys_rst_o),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.s_op_o     (s_op),
		.s_addr_o   (s_addr),
		.s_data_o   (s_wdat),
		.s_sel_o    (s_sel),
		.s_data_i   (s_rdat),
		.s_rdy_i    (s_rdy)
	);

	dev_table u_dev_table (
		.clk100mhz (clk100mhz),
		.rst_i     (sys_rst_o),
		.op_i      (s_op[s_devtbl]),
		.addr_i    (s_addr[s_devtbl]),
		.data_i    (s_wdat[s_devtbl]),
		.sel_i     (s_sel[s_devtbl]),
		.data_o    (s_rdat[s_devtbl]),
		.rdy_o     (s_rdy[s_devtbl]),
		.rst0_o    (sw_rst0),
		.rst1_o    (sw_rst1)
	);

	gpio_ctrl u_gpio (
		.clk100mhz (clk100mhz),
		.rst_i     (sys_rst_o),
		.op_i      (s_op[s_gpio]),
		.addr_i    (s_addr[s_gpio]),
		.data_i    (s_wdat[s_gpio]),
		.sel_i     (s_sel[s_gpio]),
		.data_o    (s_rdat[s_gpio]),
		.rdy_o     (s_rdy[s_gpio]),
		.gp_i      (gp_i),
		.gp_o      (gp_o),
		.intrqst_o (irq_rqst[int_src_gpio]),
		.intrdy_i  (irq_rdy[int_src_gpio])
	);

	int_ctrl u_int_ctrl (
		.clk100mhz  (clk100mhz),
		.rst_i      (sys_rst_o),
		.op_i       (s_op[s_intctrl]),
		.addr_i     (s_addr[s_intctrl]),
		.data_i     (s_wdat[s_intctrl]),
		.sel_i      (s_sel[s_intctrl]),
		.data_o     (s_rdat[s_intctrl]),
		.rdy_o      (s_rdy[s_intctrl]),
		.src_rqst_i (irq_rqst),
		.src_rdy_o  (irq_rdy),
		.intrqst_o  (intrqst_o),
		.intrdy_i   (intrdy_i)
	);

endmodule

// ==== verilog/int_ctrl.sv ====
`timescale 1ns/1ps

module int_ctrl import soc_pkg::*; (
	input  logic                     clk100mhz,
	input  logic                     rst_i,
	input  pi1_op_t                  op_i,
	input  logic [map_off_bitsz-1:0] addr_i,
	input  logic [arch_bitsz-1:0]    data_i,
	input  logic [sel_bitsz-1:0]     sel_i,
	output logic [arch_bitsz-1:0]    data_o,
	output logic                     rdy_o,
	input  logic [int_src_count-1:0] src_rqst_i,
	output logic [int_src_count-1:0] src_rdy_o,
	output logic                     intrqst_o,
	input  logic                     intrdy_i
);
	localparam int src_bitsz = $clog2(int_src_count);

	typedef enum logic [1:0] {
		st_idle,
		st_rqst,
		st_gap
	} ic_state_t;

	ic_state_t              state_q;
	logic [int_src_count-1:0] en_q;
	logic [src_bitsz-1:0]   last_src_q;
	logic [int_src_count-1:0] pending;
	logic [src_bitsz-1:0]   best;
	logic                   wr_en;
	logic [arch_bitsz-1:0]  rd_val;

	assign wr_en = ((op_i == op_wr) || (op_i == op_rdwr)) && sel_i[0];

	// lowest enabled pending source
	always_comb begin
		pending = src_rqst_i & en_q;
		best    = '0;
		for (int i = int_src_count - 1; i >= 0; i--) begin
			if (pending[i]) begin
				best = src_bitsz'(i);
			end
		end
	end

	always_comb begin
		case (addr_i)
			0:       rd_val = arch_bitsz'(last_src_q);
			1:       rd_val = arch_bitsz'(en_q);
			default: rd_val = '0;
		endcase
	end

	assign intrqst_o = (state_q == st_rqst);

	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			state_q    <= st_idle;
			en_q       <= '0;
			last_src_q <= '0;
			src_rdy_o  <= '0;
			rdy_o      <= 1'b0;
		end else begin
			rdy_o     <= (op_i != op_nop);
			src_rdy_o <= '0;
			if (wr_en && (addr_i == 1)) begin
				en_q <= data_i[int_src_count-1:0];
			end
			case (state_q)
				st_idle: begin
					if (|pending) begin
						state_q <= st_rqst;
					end
				end
				st_rqst: begin
					if (intrdy_i) begin
						state_q <= st_gap;
						if (|pending) begin
							last_src_q      <= best;
							src_rdy_o[best] <= 1'b1;
						end
					end
				end
				// one cycle low so the source can drop its request
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk100mhz) begin
		data_o <= rd_val;
	end

endmodule

// ==== verilog/gpio_ctrl.sv ====
`timescale 1ns/1ps

module gpio_ctrl import soc_pkg::*; (
	input  logic                     clk100mhz,
	input  logic                     rst_i,
	input  pi1_op_t                  op_i,
	input  logic [map_off_bitsz-1:0] addr_i,
	input  logic [arch_bitsz-1:0]    data_i,
	input  logic [sel_bitsz-1:0]     sel_i,
	output logic [arch_bitsz-1:0]    data_o,
	output logic                     rdy_o,
	input  logic [gpio_count-1:0]    gp_i,
	output logic [gpio_count-1:0]    gp_o,
	output logic                     intrqst_o,
	input  logic                     intrdy_i
);
	logic                  wr_en;
	logic [gpio_count-1:0] rd_val;
	logic [gpio_count-1:0] changed;
	logic [gpio_count-1:0] sync1_q;
	logic [gpio_count-1:0] sync2_q;
	logic [gpio_count-1:0] prev_q;
	logic [gpio_count-1:0] mask_q;

	assign wr_en = ((op_i == op_wr) || (op_i == op_rdwr)) && sel_i[0];

	always_comb begin
		case (addr_i)
			0:       rd_val = gp_o;
			1:       rd_val = sync2_q;
			2:       rd_val = mask_q;
			default: rd_val = '0;
		endcase
	end

	// two-flop synchronizer, plus one more stage for edge detection
	always_ff @(posedge clk100mhz) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	assign changed = (sync2_q ^ prev_q) & mask_q;

	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			rdy_o     <= 1'b0;
			gp_o      <= '0;
			mask_q    <= '0;
			intrqst_o <= 1'b0;
		end else begin
			rdy_o <= (op_i != op_nop);
			if (wr_en && (addr_i == 0)) begin
				gp_o <= data_i[gpio_count-1:0];
			end
			if (wr_en && (addr_i == 2)) begin
				mask_q <= data_i[gpio_count-1:0];
			end
			// a fresh change wins over the acknowledge
			if (|changed) begin
				intrqst_o <= 1'b1;
			end else if (intrdy_i) begin
				intrqst_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		data_o <= {{(arch_bitsz-gpio_count){1'b0}}, rd_val};
	end

endmodule

// ==== verilog/dev_table.sv ====
`timescale 1ns/1ps

module dev_table import soc_pkg::*; (
	input  logic                     clk100mhz,
	input  logic                     rst_i,
	input  pi1_op_t                  op_i,
	input  logic [map_off_bitsz-1:0] addr_i,
	input  logic [arch_bitsz-1:0]    data_i,
	input  logic [sel_bitsz-1:0]     sel_i,
	output logic [arch_bitsz-1:0]    data_o,
	output logic                     rdy_o,
	output logic                     rst0_o,
	output logic                     rst1_o
);
	localparam logic [map_off_bitsz-1:0] soc_id_word = map_off_bitsz'(256);

	logic [15:0]           slot_id;
	logic                  slot_int;
	logic [arch_bitsz-1:0] rd_val;
	logic                  wr_en;

	assign wr_en = ((op_i == op_wr) || (op_i == op_rdwr)) && sel_i[0];

	// two words per slave, id with the interrupt flag first, then the window size
	always_comb begin
		slot_id  = dev_id_invalid;
		slot_int = 1'b0;
		case (addr_i[2:1])
			s_devtbl:  slot_id = dev_id_devtbl;
			s_gpio: begin
				slot_id  = dev_id_gpio;
				slot_int = 1'b1;
			end
			s_intctrl: slot_id = dev_id_intctrl;
			s_invalid: slot_id = dev_id_invalid;
		endcase

		if (addr_i == soc_id_word) begin
			rd_val = {{(arch_bitsz-16){1'b0}}, soc_id};
		end else if (addr_i[map_off_bitsz-1:3] != '0) begin
			rd_val = '0;
		end else if (addr_i[0]) begin
			rd_val = arch_bitsz'(map_sz_words);
		end else begin
			rd_val = {{(arch_bitsz-17){1'b0}}, slot_int, slot_id};
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			rdy_o  <= 1'b0;
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else begin
			rdy_o  <= (op_i != op_nop);
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
			// reset request bits only live for one cycle
			if (wr_en && (addr_i == soc_id_word)) begin
				rst0_o <= data_i[0];
				rst1_o <= data_i[1];
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		data_o <= rd_val;
	end

endmodule

// ==== verilog/pi1_router.sv ====
`timescale 1ns/1ps

module pi1_router import soc_pkg::*; (
	input  logic                     clk100mhz,
	input  logic                     rst_i,
	input  pi1_op_t                  pi1_op_i,
	input  logic [addr_bitsz-1:0]    pi1_addr_i,
	input  logic [arch_bitsz-1:0]    pi1_data_i,
	input  logic [sel_bitsz-1:0]     pi1_sel_i,
	output logic [arch_bitsz-1:0]    pi1_data_o,
	output logic                     pi1_rdy_o,
	output pi1_op_t                  s_op_o   [slave_count-1],
	output logic [map_off_bitsz-1:0] s_addr_o [slave_count-1],
	output logic [arch_bitsz-1:0]    s_data_o [slave_count-1],
	output logic [sel_bitsz-1:0]     s_sel_o  [slave_count-1],
	input  logic [arch_bitsz-1:0]    s_data_i [slave_count-1],
	input  logic                     s_rdy_i  [slave_count-1]
);
	logic [addr_bitsz-map_off_bitsz-1:0] region;
	logic [1:0]                          dec_idx;
	logic                                accept;

	logic                     busy_q;
	pi1_op_t                  fwd_op_q;
	logic [1:0]               fwd_idx_q;
	logic                     inv_rdy_q;
	logic [map_off_bitsz-1:0] fwd_addr_q;
	logic [arch_bitsz-1:0]    fwd_data_q;
	logic [sel_bitsz-1:0]     fwd_sel_q;

	// window number from the upper address bits; anything past the last slave is invalid
	always_comb begin
		region = pi1_addr_i[addr_bitsz-1:map_off_bitsz];
		if (region < (slave_count - 1)) begin
			dec_idx = region[1:0];
		end else begin
			dec_idx = s_invalid;
		end
	end

	assign accept = !busy_q && (pi1_op_i != op_nop);

	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			busy_q    <= 1'b0;
			fwd_op_q  <= op_nop;
			fwd_idx_q <= s_invalid;
			inv_rdy_q <= 1'b0;
		end else begin
			// op to the slave is a single-cycle pulse
			fwd_op_q  <= op_nop;
			inv_rdy_q <= (fwd_op_q != op_nop) && (fwd_idx_q == s_invalid);
			if (accept) begin
				busy_q    <= 1'b1;
				fwd_op_q  <= pi1_op_i;
				fwd_idx_q <= dec_idx;
			end else if (pi1_rdy_o) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (accept) begin
			fwd_addr_q <= pi1_addr_i[map_off_bitsz-1:0];
			fwd_data_q <= pi1_data_i;
			fwd_sel_q  <= pi1_sel_i;
		end
	end

	always_comb begin
		for (int k = 0; k < slave_count - 1; k++) begin
			if (fwd_idx_q == k) begin
				s_op_o[k] = fwd_op_q;
			end else begin
				s_op_o[k] = op_nop;
			end
			s_addr_o[k] = fwd_addr_q;
			s_data_o[k] = fwd_data_q;
			s_sel_o[k]  = fwd_sel_q;
		end
	end

	// the invalid slave answers with zero data
	always_comb begin
		if (fwd_idx_q == s_invalid) begin
			pi1_data_o = '0;
			pi1_rdy_o  = busy_q && inv_rdy_q;
		end else begin
			pi1_data_o = s_data_i[fwd_idx_q];
			pi1_rdy_o  = busy_q && s_rdy_i[fwd_idx_q];
		end
	end

endmodule

// ==== verilog/soc_reset.sv ====
`timescale 1ns/1ps

module soc_reset #(
	parameter int rst_cntr_bitsz = 16
) (
	input  logic clk100mhz,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);
	logic [rst_cntr_bitsz-1:0] rst_cntr_q;
	logic                      pwr_off_q;
	logic                      warm_rqst;
	logic                      pwr_off_rqst;

	// rst1 alone is warm, rst0 with rst1 is cold and handled the same way
	assign warm_rqst    = rst1_i;
	assign pwr_off_rqst = rst0_i && !rst1_i;

	// counts down to zero once the reset source is gone
	always_ff @(posedge clk100mhz) begin
		if (rst_p || warm_rqst) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// power-off stays latched until the board reset comes back
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (pwr_off_rqst) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr_q != '0) || pwr_off_q;

endmodule

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

	// bus opcodes; rdwr returns the old value and writes the new one
	typedef enum logic [1:0] {
		op_nop  = 2'd0,
		op_wr   = 2'd1,
		op_rd   = 2'd2,
		op_rdwr = 2'd3
	} pi1_op_t;

	localparam int arch_bitsz = 32;
	localparam int addr_bitsz = 30;
	localparam int sel_bitsz  = arch_bitsz / 8;

	// slave indices, laid out back to back from word 0 in this order
	localparam int          slave_count = 4;
	localparam logic [1:0]  s_devtbl    = 2'd0;
	localparam logic [1:0]  s_gpio      = 2'd1;
	localparam logic [1:0]  s_intctrl   = 2'd2;
	localparam logic [1:0]  s_invalid   = 2'd3;

	// every slave window has the same size in words
	localparam int map_sz_words  = 1024;
	localparam int map_off_bitsz = $clog2(map_sz_words);

	localparam logic [15:0] dev_id_devtbl  = 16'd7;
	localparam logic [15:0] dev_id_gpio    = 16'd6;
	localparam logic [15:0] dev_id_intctrl = 16'd3;
	localparam logic [15:0] dev_id_invalid = 16'd0;
	localparam logic [15:0] soc_id         = 16'd3;

	// interrupt sources, lower index wins arbitration
	localparam int int_src_gpio  = 0;
	localparam int int_src_ext   = 1;
	localparam int int_src_count = 2;

	localparam int gpio_count = 8;

endpackage
